//--- run.sh
#!/bin/bash
# build and run the dcache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -Mdir obj_dir -f vlog.f
./obj_dir/Vtb_dcache | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi

//--- src/cache_ctrl.sv
module cache_ctrl (
	input logic clk,
	input logic rst_n,
	input logic cpu_re,
	input logic cpu_we,
	input logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
	input dcache_pkg::be_t cpu_byte_enable,
	input dcache_pkg::word_t cpu_wdata,
	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input logic victim_dirty,
	input dcache_pkg::tag_t victim_tag,
	input mem_bus_pkg::beat_t beat,
	input logic beat_strobe,
	input dcache_pkg::word_t fill_word,
	input logic done,
	output logic cpu_stall,
	output logic rdata_way_sel,
	output logic touch,
	output logic mark_dirty,
	output logic install,
	output logic clean,
	output logic start_fill,
	output logic start_wb,
	output logic [dcache_pkg::ADDR_W-1:0] line_addr,
	output logic [dcache_pkg::INDEX_W+dcache_pkg::OFFSET_W-1:0] way0_addr,
	output logic [dcache_pkg::INDEX_W+dcache_pkg::OFFSET_W-1:0] way1_addr,
	output dcache_pkg::be_t way0_we,
	output dcache_pkg::be_t way1_we,
	output dcache_pkg::word_t way_wdata
);
	import dcache_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_RESPOND, S_WRITEBACK, S_FILL, S_INSTALL} state_t;

	state_t state;
	state_t state_next;
	tag_t cpu_tag;
	index_t cpu_index;
	offset_t cpu_offset;
	logic req;
	logic accept;
	logic miss;
	logic [INDEX_W+OFFSET_W-1:0] ram_addr;
	logic [INDEX_W+OFFSET_W-1:0] wr_addr_q;
	be_t wr_be_q;
	word_t wr_data_q;
	be_t resp_be;
	be_t fill_be;

	// word address, byte bits dropped
	assign {cpu_tag, cpu_index, cpu_offset} = cpu_addr[ADDR_W-1:2];

	assign req = cpu_re || cpu_we;
	assign accept = (state == S_IDLE) && req && hit;
	assign miss = (state == S_IDLE) && req && !hit;

	assign cpu_stall = !((state == S_IDLE) && hit);
	assign touch = accept;
	assign mark_dirty = accept && cpu_we;

	// dirty victim goes out first, the fill follows its done
	assign start_wb = miss && victim_dirty;
	assign start_fill = (miss && !victim_dirty) || ((state == S_WRITEBACK) && done);
	assign clean = (state == S_WRITEBACK) && done;
	assign install = state == S_INSTALL;

	assign line_addr = start_wb ? {victim_tag, cpu_index, {(OFFSET_W + 2){1'b0}}}
		: {cpu_tag, cpu_index, {(OFFSET_W + 2){1'b0}}};

	always_comb
	begin
		case (state)
			S_RESPOND:
				ram_addr = wr_addr_q;
			S_WRITEBACK, S_FILL:
				ram_addr = {cpu_index, beat};
			default:
				ram_addr = {cpu_index, cpu_offset};
		endcase
	end

	assign way0_addr = ram_addr;
	assign way1_addr = ram_addr;

	// hit write lands in the respond cycle, fill beats go to the victim
	assign resp_be = (state == S_RESPOND) ? wr_be_q : '0;
	assign fill_be = ((state == S_FILL) && beat_strobe) ? '1 : '0;
	assign way0_we = (rdata_way_sel ? '0 : resp_be) | (victim_way ? '0 : fill_be);
	assign way1_we = (rdata_way_sel ? resp_be : '0) | (victim_way ? fill_be : '0);
	assign way_wdata = (state == S_RESPOND) ? wr_data_q : fill_word;

	always_comb
	begin
		state_next = state;
		case (state)
			S_IDLE:
			begin
				if (accept)
					state_next = S_RESPOND;
				else if (miss)
					state_next = victim_dirty ? S_WRITEBACK : S_FILL;
			end
			S_RESPOND:
				state_next = S_IDLE;
			S_WRITEBACK:
			begin
				if (done)
					state_next = S_FILL;
			end
			S_FILL:
			begin
				if (done)
					state_next = S_INSTALL;
			end
			S_INSTALL:
				state_next = S_IDLE;
			default:
				state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			rdata_way_sel <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (accept)
				rdata_way_sel <= hit_way;
		end
	end

	// captured at acceptance, used in the respond cycle
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr_addr_q <= {cpu_index, cpu_offset};
			wr_be_q <= cpu_we ? cpu_byte_enable : '0;
			wr_data_q <= cpu_wdata;
		end
	end

endmodule

//--- src/data_way.sv
module data_way (
	input logic clk,
	input logic [dcache_pkg::INDEX_W+dcache_pkg::OFFSET_W-1:0] addr,
	input dcache_pkg::be_t we,
	input dcache_pkg::word_t wdata,
	output dcache_pkg::word_t rdata
);
	import dcache_pkg::*;

	// one word per entry, addressed as {index, offset}
	word_t mem [NUM_SETS << OFFSET_W];

	always_ff @(posedge clk)
	begin
		// per-byte write
		for (int b = 0; b < $bits(be_t); b++)
		begin
			if (we[b])
				mem[addr][8*b +: 8] <= wdata[8*b +: 8];
		end
		// read returns the old word on a same-address write
		rdata <= mem[addr];
	end

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

	// byte address as seen by the cpu
	localparam int ADDR_W = 32;

	// 16 words per line, 16 sets, two ways
	localparam int OFFSET_W = 4;
	localparam int INDEX_W = 4;
	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 2;

	// whatever is left above index, offset and the two byte bits
	localparam int TAG_W = 22;

	typedef logic [31:0] word_t;
	typedef logic [3:0] be_t;

	// address fields, tag | index | offset | byte
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

endpackage

//--- src/dcache_top.sv
module dcache_top (
	input logic clk,
	input logic rst_n,
	input logic cpu_re,
	input logic cpu_we,
	input logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
	input dcache_pkg::be_t cpu_byte_enable,
	input dcache_pkg::word_t cpu_wdata,
	output dcache_pkg::word_t cpu_rdata,
	output logic cpu_stall,
	output logic [dcache_pkg::ADDR_W-1:0] araddr,
	output logic arvalid,
	input logic arready,
	input dcache_pkg::word_t rdata,
	input logic rvalid,
	input logic rlast,
	output logic rready,
	output logic [dcache_pkg::ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output dcache_pkg::word_t wdata,
	output logic wvalid,
	output logic wlast,
	input logic wready
);
	import dcache_pkg::*;
	import mem_bus_pkg::*;

	index_t lookup_index;
	tag_t lookup_tag;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	tag_t victim_tag;
	logic touch;
	logic mark_dirty;
	logic install;
	logic clean;
	logic start_fill;
	logic start_wb;
	logic [ADDR_W-1:0] line_addr;
	beat_t beat;
	logic beat_strobe;
	word_t fill_word;
	logic done;
	logic rdata_way_sel;
	logic [INDEX_W+OFFSET_W-1:0] way0_addr;
	logic [INDEX_W+OFFSET_W-1:0] way1_addr;
	be_t way0_we;
	be_t way1_we;
	word_t way_wdata;
	word_t way0_rdata;
	word_t way1_rdata;
	word_t victim_rdata;

	assign lookup_tag = cpu_addr[ADDR_W-1 -: TAG_W];
	assign lookup_index = cpu_addr[ADDR_W-TAG_W-1 -: INDEX_W];

	assign cpu_rdata = rdata_way_sel ? way1_rdata : way0_rdata;
	// writeback streams out of the victim way
	assign victim_rdata = victim_way ? way1_rdata : way0_rdata;

	cache_ctrl ctrl_i (
		.clk(clk), .rst_n(rst_n),
		.cpu_re(cpu_re), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
		.cpu_byte_enable(cpu_byte_enable), .cpu_wdata(cpu_wdata),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.victim_dirty(victim_dirty), .victim_tag(victim_tag),
		.beat(beat), .beat_strobe(beat_strobe), .fill_word(fill_word), .done(done),
		.cpu_stall(cpu_stall), .rdata_way_sel(rdata_way_sel),
		.touch(touch), .mark_dirty(mark_dirty), .install(install), .clean(clean),
		.start_fill(start_fill), .start_wb(start_wb), .line_addr(line_addr),
		.way0_addr(way0_addr), .way1_addr(way1_addr),
		.way0_we(way0_we), .way1_we(way1_we), .way_wdata(way_wdata)
	);

	tag_store tag_i (
		.clk(clk), .rst_n(rst_n),
		.lookup_index(lookup_index), .lookup_tag(lookup_tag),
		.touch(touch), .hit_way_in(hit_way), .mark_dirty(mark_dirty),
		.install(install), .clean(clean),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.victim_dirty(victim_dirty), .victim_tag(victim_tag)
	);

	line_burst burst_i (
		.clk(clk), .rst_n(rst_n),
		.start_fill(start_fill), .start_wb(start_wb), .line_addr(line_addr),
		.arready(arready), .awready(awready), .wready(wready),
		.rvalid(rvalid), .rdata(rdata), .rlast(rlast), .way_rdata(victim_rdata),
		.araddr(araddr), .arvalid(arvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid),
		.wdata(wdata), .wvalid(wvalid), .wlast(wlast),
		.beat(beat), .beat_strobe(beat_strobe), .fill_word(fill_word), .done(done)
	);

	data_way way0_i (
		.clk(clk), .addr(way0_addr), .we(way0_we), .wdata(way_wdata), .rdata(way0_rdata)
	);

	data_way way1_i (
		.clk(clk), .addr(way1_addr), .we(way1_we), .wdata(way_wdata), .rdata(way1_rdata)
	);

endmodule

//--- src/line_burst.sv
module line_burst (
	input logic clk,
	input logic rst_n,
	input logic start_fill,
	input logic start_wb,
	input logic [dcache_pkg::ADDR_W-1:0] line_addr,
	input logic arready,
	input logic awready,
	input logic wready,
	input logic rvalid,
	input dcache_pkg::word_t rdata,
	input logic rlast,
	input dcache_pkg::word_t way_rdata,
	output logic [dcache_pkg::ADDR_W-1:0] araddr,
	output logic arvalid,
	output logic rready,
	output logic [dcache_pkg::ADDR_W-1:0] awaddr,
	output logic awvalid,
	output dcache_pkg::word_t wdata,
	output logic wvalid,
	output logic wlast,
	output mem_bus_pkg::beat_t beat,
	output logic beat_strobe,
	output dcache_pkg::word_t fill_word,
	output logic done
);
	import dcache_pkg::*;
	import mem_bus_pkg::*;

	typedef enum logic [2:0] {PH_IDLE, PH_AR, PH_R, PH_AW, PH_W} phase_t;

	phase_t phase;
	logic [ADDR_W-1:0] addr_q;
	// w beats sent so far
	beat_t wcnt;
	word_t hold_q;
	logic hold_valid;

	assign araddr = addr_q;
	assign awaddr = addr_q;
	assign fill_word = rdata;

	// stalled beat keeps its word in the hold register
	assign wdata = hold_valid ? hold_q : way_rdata;
	assign wlast = wvalid && (wcnt == beat_t'(BURST_BEATS - 1));

	// in a writeback, beat is the ram read pointer, one ahead of wcnt
	assign beat_strobe = (phase == PH_R && rvalid) || (phase == PH_W && wready);

	always_ff @(posedge clk)
	begin
		if (start_fill || start_wb)
			addr_q <= line_addr;
		if (phase == PH_W && !wready && !hold_valid)
			hold_q <= way_rdata;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase <= PH_IDLE;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			hold_valid <= 1'b0;
			beat <= '0;
			wcnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (phase)
				PH_IDLE:
				begin
					beat <= '0;
					wcnt <= '0;
					if (start_fill)
					begin
						arvalid <= 1'b1;
						rready <= 1'b1;
						phase <= PH_AR;
					end
					else if (start_wb)
					begin
						awvalid <= 1'b1;
						phase <= PH_AW;
					end
				end
				PH_AR:
				begin
					if (arready)
					begin
						arvalid <= 1'b0;
						phase <= PH_R;
					end
				end
				PH_R:
				begin
					if (rvalid)
					begin
						beat <= beat + 1'b1;
						// rlast cuts a short burst off as well
						if (beat == beat_t'(BURST_BEATS - 1) || rlast)
						begin
							rready <= 1'b0;
							done <= 1'b1;
							phase <= PH_IDLE;
						end
					end
				end
				PH_AW:
				begin
					// ram already reads word 0 here
					if (awready)
					begin
						awvalid <= 1'b0;
						wvalid <= 1'b1;
						beat <= beat + 1'b1;
						phase <= PH_W;
					end
				end
				PH_W:
				begin
					if (wready)
					begin
						hold_valid <= 1'b0;
						beat <= beat + 1'b1;
						wcnt <= wcnt + 1'b1;
						if (wlast)
						begin
							wvalid <= 1'b0;
							done <= 1'b1;
							phase <= PH_IDLE;
						end
					end
					else if (!hold_valid)
						hold_valid <= 1'b1;
				end
				default:
					phase <= PH_IDLE;
			endcase
		end
	end

endmodule

//--- src/mem_bus_pkg.sv
package mem_bus_pkg;

	// one word per beat, so a line is one full burst
	localparam int BURST_BEATS = 16;

	// counts beats within a burst
	typedef logic [$clog2(BURST_BEATS)-1:0] beat_t;

endpackage

//--- src/tag_store.sv
module tag_store (
	input logic clk,
	input logic rst_n,
	input dcache_pkg::index_t lookup_index,
	input dcache_pkg::tag_t lookup_tag,
	input logic touch,
	input logic hit_way_in,
	input logic mark_dirty,
	input logic install,
	input logic clean,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic victim_dirty,
	output dcache_pkg::tag_t victim_tag
);
	import dcache_pkg::*;

	tag_t tags [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid [NUM_WAYS];
	logic [NUM_SETS-1:0] dirty [NUM_WAYS];
	// one bit per set, names the way to evict next
	logic [NUM_SETS-1:0] lru;
	logic [NUM_WAYS-1:0] way_hit;

	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			way_hit[w] = valid[w][lookup_index] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// victim follows lru only
	assign victim_way = lru[lookup_index];
	assign victim_dirty = valid[victim_way][lookup_index] && dirty[victim_way][lookup_index];
	assign victim_tag = tags[victim_way][lookup_index];

	always_ff @(posedge clk)
	begin
		if (install)
			tags[victim_way][lookup_index] <= lookup_tag;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			lru <= '0;
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				valid[w] <= '0;
				dirty[w] <= '0;
			end
		end
		else if (install)
		begin
			// freshly filled line, clean and most recently used
			valid[victim_way][lookup_index] <= 1'b1;
			dirty[victim_way][lookup_index] <= 1'b0;
			lru[lookup_index] <= ~victim_way;
		end
		else
		begin
			if (touch)
				lru[lookup_index] <= ~hit_way_in;
			if (mark_dirty)
				dirty[hit_way_in][lookup_index] <= 1'b1;
			// victim was just written back
			if (clean)
				dirty[victim_way][lookup_index] <= 1'b0;
		end
	end

endmodule

//--- test/dcache_sva.sv
module dcache_sva (
	input logic clk,
	input logic rst_n,
	input logic cpu_stall,
	input logic [31:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic [31:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	input logic wready,
	input logic wlast
);

	// r beats since the last ar transfer
	logic [4:0] r_cnt;
	// w beats since the last aw transfer
	logic [3:0] w_cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			r_cnt <= '0;
		else if (arvalid && arready)
			r_cnt <= '0;
		else if (rvalid && rready)
			r_cnt <= r_cnt + 5'd1;
		else if (!cpu_stall)
			r_cnt <= '0;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			w_cnt <= '0;
		else if (awvalid && awready)
			w_cnt <= '0;
		else if (wvalid && wready)
			w_cnt <= w_cnt + 4'd1;
	end

	// bus idle right after reset
	reset_idle: assert property (@(posedge clk)
		!rst_n |=> !arvalid && !awvalid && !wvalid && !wlast && !rready)
		else $error("memory channels active after reset");

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before transfer");

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid or awaddr changed before transfer");

	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
		else $error("wvalid, wdata or wlast changed before transfer");

	line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(!arvalid || araddr[5:0] == 6'd0) && (!awvalid || awaddr[5:0] == 6'd0))
		else $error("burst address not at a line base");

	wlast_on_16th: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && wready |-> wlast == (w_cnt == 4'd15))
		else $error("wlast not on the 16th write beat");

	// a fill is complete before the cpu is released
	full_fill: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cpu_stall) |-> (r_cnt == 5'd0 || r_cnt == 5'd16))
		else $error("cpu released without a full 16 beat fill");

	stall_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		(arvalid || rready || awvalid || wvalid) |-> cpu_stall)
		else $error("cpu not stalled during a burst");

endmodule

bind dcache_top dcache_sva sva_i (
	.clk(clk), .rst_n(rst_n), .cpu_stall(cpu_stall),
	.araddr(araddr), .arvalid(arvalid), .arready(arready),
	.rvalid(rvalid), .rready(rready),
	.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
	.wdata(wdata), .wvalid(wvalid), .wready(wready), .wlast(wlast)
);

//--- test/tb_dcache.sv
module tb_dcache;
	import dcache_pkg::*;

	localparam int NUM_OPS = 300;
	localparam int DIRECTED_OPS = 6;
	localparam int CYCLES_PER_OP = 80;
	localparam int MAX_CYCLES = (NUM_OPS + DIRECTED_OPS) * CYCLES_PER_OP;
	localparam int MEM_WORDS = 4096;

	logic clk;
	logic rst_n;
	logic cpu_re;
	logic cpu_we;
	logic [31:0] cpu_addr;
	be_t cpu_byte_enable;
	word_t cpu_wdata;
	word_t cpu_rdata;
	logic cpu_stall;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	word_t rdata;
	logic rvalid;
	logic rlast;
	logic rready;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	word_t wdata;
	logic wvalid;
	logic wlast;
	logic wready;

	word_t mem [MEM_WORDS];
	word_t shadow [MEM_WORDS];
	logic [31:0] mem_seed;
	logic [31:0] stim_seed;
	logic reading;
	logic [11:0] rbase;
	logic [4:0] rcount;
	logic [11:0] wbase;
	logic [4:0] wcount;
	int errors;
	int reads_checked;
	int writebacks;
	int cycles;

	dcache_top dcache_top_i (
		.clk(clk), .rst_n(rst_n),
		.cpu_re(cpu_re), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
		.cpu_byte_enable(cpu_byte_enable), .cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata), .cpu_stall(cpu_stall),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wlast(wlast), .wready(wready)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// four tags share every index
	function automatic logic [31:0] make_addr(input logic [1:0] tag, input index_t idx,
		input offset_t off);
		return {20'd0, tag, idx, off, 2'b00};
	endfunction

	task automatic compare_line(input logic [11:0] base);
		logic [11:0] a;
		for (int i = 0; i < 16; i++)
		begin
			a = {base[11:4], i[3:0]};
			assert (mem[a] == shadow[a])
			else
			begin
				errors++;
				$display("FAIL mem[%h] got %h expected %h", a, mem[a], shadow[a]);
			end
		end
	endtask

	// memory model, samples at the edge and drives 10 units later
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			reading = 1'b0;
		end
		else
		begin
			if (arvalid && arready)
			begin
				rbase = araddr[13:2];
				rcount = '0;
				reading = 1'b1;
			end
			if (rvalid && rready)
			begin
				if (rcount == 5'd15)
					reading = 1'b0;
				rcount = rcount + 5'd1;
			end
			if (awvalid && awready)
			begin
				wbase = awaddr[13:2];
				wcount = '0;
			end
			if (wvalid && wready)
			begin
				mem[{wbase[11:4], wcount[3:0]}] = wdata;
				assert (wlast == (wcount == 5'd15))
				else
				begin
					errors++;
					$display("FAIL wlast got %h expected %h", wlast, wcount == 5'd15);
				end
				if (wcount == 5'd15)
				begin
					writebacks++;
					compare_line(wbase);
				end
				wcount = wcount + 5'd1;
			end
		end
		#10;
		mem_seed = lcg_next(mem_seed);
		// ready and valid gaps about one cycle in four
		arready = mem_seed[17:16] != 2'b00;
		awready = mem_seed[19:18] != 2'b00;
		wready = mem_seed[21:20] != 2'b00;
		rvalid = reading && (mem_seed[23:22] != 2'b00);
		rdata = mem[{rbase[11:4], rcount[3:0]}];
		rlast = reading && (rcount == 5'd15);
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, the cache stopped accepting requests", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// starts and ends 10 units after an edge
	task automatic cpu_access(input logic write, input logic [31:0] addr, input be_t be,
		input word_t data);
		word_t expected;
		logic accepted;
		cpu_re = !write;
		cpu_we = write;
		cpu_addr = addr;
		cpu_byte_enable = be;
		cpu_wdata = data;
		accepted = 1'b0;
		while (!accepted)
		begin
			@(posedge clk);
			accepted = !cpu_stall;
		end
		expected = shadow[addr[13:2]];
		if (write)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (be[b])
					shadow[addr[13:2]][8*b +: 8] = data[8*b +: 8];
			end
		end
		#10;
		cpu_re = 1'b0;
		cpu_we = 1'b0;
		@(posedge clk);
		if (!write)
		begin
			reads_checked++;
			assert (cpu_rdata == expected)
			else
			begin
				errors++;
				$display("FAIL cpu_rdata got %h expected %h at address %h",
					cpu_rdata, expected, addr);
			end
		end
		#10;
	endtask

	initial
	begin
		logic [31:0] s;
		logic [31:0] a;
		clk = 1'b0;
		rst_n = 1'b0;
		cpu_re = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_byte_enable = '0;
		cpu_wdata = '0;
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		reading = 1'b0;
		rbase = '0;
		rcount = '0;
		wbase = '0;
		wcount = '0;
		errors = 0;
		reads_checked = 0;
		writebacks = 0;
		cycles = 0;
		mem_seed = 32'h22a9_30f1;
		stim_seed = 32'h22a9_30f1;
		s = 32'h22a9_30f1;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			s = lcg_next(s);
			mem[i] = s ^ i;
			shadow[i] = s ^ i;
		end
		mem_seed = lcg_next(s);
		stim_seed = lcg_next(mem_seed);

		repeat (4) @(posedge clk);
		#10;
		rst_n = 1'b1;

		// partial write merge, then a third tag evicts a dirty line
		a = make_addr(2'd0, 4'd5, 4'd3);
		cpu_access(1'b1, a, 4'b0110, 32'hdead_beef);
		cpu_access(1'b0, a, 4'b0000, '0);
		cpu_access(1'b1, make_addr(2'd1, 4'd5, 4'd9), 4'b1111, 32'h1234_5678);
		cpu_access(1'b0, make_addr(2'd2, 4'd5, 4'd0), 4'b0000, '0);
		cpu_access(1'b0, a, 4'b0000, '0);
		cpu_access(1'b0, make_addr(2'd1, 4'd5, 4'd9), 4'b0000, '0);

		for (int n = 0; n < NUM_OPS; n++)
		begin
			stim_seed = lcg_next(stim_seed);
			s = stim_seed;
			stim_seed = lcg_next(stim_seed);
			cpu_access(s[18], make_addr(s[9:8], s[13:10], s[17:14]), s[22:19], stim_seed);
		end

		$display("reads checked %0d, writebacks %0d, errors %0d",
			reads_checked, writebacks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- vlog.f
src/dcache_pkg.sv
src/mem_bus_pkg.sv
src/tag_store.sv
src/data_way.sv
src/line_burst.sv
src/cache_ctrl.sv
src/dcache_top.sv
test/dcache_sva.sv
test/tb_dcache.sv
